// ==== pe_row.f ====
+incdir+bench
hw/pe_row_pkg.sv
hw/caster.sv
hw/multi_caster.sv
hw/mac_pe.sv
hw/result_collector.sv
hw/pe_row.sv
bench/pe_row_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the pe_row testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f pe_row.f --top-module pe_row_tb -o pe_row_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/pe_row_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

// ==== bench/pe_row_model.svh ====
`ifndef PE_ROW_MODEL_SVH
`define PE_ROW_MODEL_SVH

// mirrored tag tables, one row per kind
logic                m_valid [3][num_col];
logic [id_w-1:0]     m_tag   [3][num_col];

// mirrored PE operand registers
logic [data_w-1:0]   m_ifmap [num_col];
logic [data_w-1:0]   m_fltr  [num_col];

// predicted results, oldest first
result_t             exp_q [$];

function automatic void model_reset();
    for (int k = 0; k < 3; k++) begin
        for (int c = 0; c < num_col; c++) begin
            m_valid[k][c] = 1'b0;
            m_tag[k][c]   = '0;
        end
    end
    for (int c = 0; c < num_col; c++) begin
        m_ifmap[c] = '0;
        m_fltr[c]  = '0;
    end
    exp_q.delete();
endfunction

// psum plus signed 16x16 product, wrapped to 32 bits
function automatic logic [psum_w-1:0] mac_value(input logic [psum_w-1:0] acc,
                                                input logic [data_w-1:0] a,
                                                input logic [data_w-1:0] b);
    int prod;
    prod = int'($signed(a)) * int'($signed(b));
    return acc + psum_w'(prod);
endfunction

// one packet as the row sees it
function automatic void model_apply(input bus_pkt_t p);
    int      k;
    result_t r;
    k = int'(p.kind);
    if (p.op == op_cfg) begin
        m_valid[k][p.col] = 1'b1;
        m_tag[k][p.col]   = p.id;
    end else begin
        // ascending scan gives the collector order
        for (int c = 0; c < num_col; c++) begin
            if (m_valid[k][c] && m_tag[k][c] == p.id) begin
                case (p.kind)
                    kind_ifmap: m_ifmap[c] = p.data[data_w-1:0];
                    kind_fltr:  m_fltr[c]  = p.data[data_w-1:0];
                    default: begin
                        r.col   = col_w'(c);
                        r.value = mac_value(p.data, m_ifmap[c], m_fltr[c]);
                        exp_q.push_back(r);
                    end
                endcase
            end
        end
    end
endfunction

`endif

// ==== bench/pe_row_tb.sv ====
`timescale 1ns/1ps

module pe_row_tb import pe_row_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      bus_stb;
    bus_pkt_t  pkt;
    logic      out_stb;
    result_t   out;

    // monitor state
    int        cyc;
    int        psum_cyc;
    result_t   got_q [$];
    int        lat_q [$];

    // per-test tallies
    int        pass_cnt;
    int        fail_cnt;

    `include "pe_row_model.svh"

    pe_row UUT (
        .clk     (clk),
        .reset   (reset),
        .bus_stb (bus_stb),
        .pkt     (pkt),
        .out_stb (out_stb),
        .out     (out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // latency counted from the edge that samples the psum strobe
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (!reset && bus_stb && pkt.op == op_data && pkt.kind == kind_psum) begin
            psum_cyc <= cyc;
        end
        if (!reset && out_stb) begin
            got_q.push_back(out);
            lat_q.push_back(cyc - psum_cyc);
        end
    end

    function automatic bus_pkt_t make_pkt(input bus_op_e op, input data_kind_e kind,
                                          input int col, input int id,
                                          input logic [psum_w-1:0] data);
        bus_pkt_t p;
        p.op   = op;
        p.kind = kind;
        p.col  = col_w'(col);
        p.id   = id_w'(id);
        p.data = data;
        return p;
    endfunction

    // corner values weighted heavily
    function automatic logic [data_w-1:0] pick_half();
        case ($urandom_range(0, 4))
            0:       return 16'h8000;
            1:       return 16'h7fff;
            2:       return 16'hffff;
            3:       return 16'h0001;
            default: return 16'($urandom);
        endcase
    endfunction

    function automatic logic [psum_w-1:0] pick_word();
        case ($urandom_range(0, 3))
            0:       return 32'h8000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'hffff_ffff;
            default: return 32'($urandom);
        endcase
    endfunction

    function automatic bus_pkt_t random_pkt();
        bus_pkt_t p;
        int       r;
        p.op = ($urandom_range(0, 3) == 0) ? op_cfg : op_data;
        r = int'($urandom_range(0, 2));
        p.kind = (r == 0) ? kind_ifmap : ((r == 1) ? kind_fltr : kind_psum);
        p.col = col_w'($urandom_range(0, num_col - 1));
        // narrow tag range so data packets hit often
        p.id = id_w'($urandom_range(0, 3));
        // junk in the upper half checks the slicing
        if (p.kind == kind_psum) begin
            p.data = pick_word();
        end else begin
            p.data = {16'($urandom), pick_half()};
        end
        return p;
    endfunction

    // one packet, then the bus goes idle
    task automatic send(input bus_pkt_t p);
        @(posedge clk);
        bus_stb <= 1'b1;
        pkt     <= p;
        model_apply(p);
        @(posedge clk);
        bus_stb <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    // bounded wait, then a few quiet cycles to catch extras
    task automatic wait_results(input string name, input int n, inout int errs);
        int t;
        t = 0;
        while (got_q.size() < n && t < 400) begin
            @(posedge clk);
            t++;
        end
        if (got_q.size() < n) begin
            $display("%s: timed out waiting for %0d results, %0d arrived",
                     name, n, got_q.size());
            errs++;
        end
        idle(num_col + 3);
    endtask

    task automatic check_results(input string name, input bit check_lat, inout int errs);
        int n;
        if (got_q.size() != exp_q.size()) begin
            $display("error %s result count: expected %0d actual %0d",
                     name, exp_q.size(), got_q.size());
            errs++;
        end
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            if (got_q[i] != exp_q[i]) begin
                $display("error %s result %0d: expected col %0d value %h actual col %0d value %h",
                         name, i, exp_q[i].col, exp_q[i].value, got_q[i].col, got_q[i].value);
                errs++;
            end
            // k hits drain on k consecutive cycles from 3
            if (check_lat && lat_q[i] != 3 + i) begin
                $display("error %s latency of result %0d: expected %0d actual %0d",
                         name, i, 3 + i, lat_q[i]);
                errs++;
            end
        end
        got_q.delete();
        lat_q.delete();
        exp_q.delete();
    endtask

    task automatic report(input string name, input int errs);
        if (errs == 0) begin
            $display("test %s: ok", name);
            pass_cnt++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, errs);
            fail_cnt++;
        end
    endtask

    initial begin
        int errs;
        void'($urandom(32'h75e9));
        reset    = 1'b1;
        bus_stb  = 1'b0;
        pkt      = '0;
        cyc      = 0;
        psum_cyc = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        model_reset();
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // idle row, then psum into an empty tag table
        errs = 0;
        idle(20);
        send(make_pkt(op_data, kind_psum, 0, 0, 32'd55));
        wait_results("reset_idle", 0, errs);
        check_results("reset_idle", 1'b0, errs);
        report("reset_idle", errs);

        // distinct tags, ifmap 1..4, filter 5..8, psum 9..12
        errs = 0;
        for (int c = 0; c < num_col; c++) begin
            send(make_pkt(op_cfg, kind_ifmap, c, c + 1, '0));
            send(make_pkt(op_cfg, kind_fltr, c, c + 5, '0));
            send(make_pkt(op_cfg, kind_psum, c, c + 9, '0));
        end
        send(make_pkt(op_data, kind_ifmap, 0, 3, 32'h0000_0007));
        send(make_pkt(op_data, kind_fltr, 0, 7, 32'h0000_fffa));
        send(make_pkt(op_data, kind_psum, 0, 11, 32'd1000));
        wait_results("unicast", 1, errs);
        check_results("unicast", 1'b1, errs);
        report("unicast", errs);

        // shared filter and psum tags, own ifmap per column
        errs = 0;
        for (int c = 0; c < num_col; c++) begin
            send(make_pkt(op_cfg, kind_fltr, c, 14, '0));
            send(make_pkt(op_cfg, kind_psum, c, 15, '0));
            send(make_pkt(op_data, kind_ifmap, 0, c + 1, 32'(c * 37 - 50)));
        end
        send(make_pkt(op_data, kind_fltr, 0, 14, 32'h0000_fffd));
        send(make_pkt(op_data, kind_psum, 0, 15, 32'd123456));
        wait_results("multicast", num_col, errs);
        check_results("multicast", 1'b1, errs);
        report("multicast", errs);

        // column 1 moves from psum tag 15 to 13
        errs = 0;
        send(make_pkt(op_cfg, kind_psum, 1, 13, '0));
        send(make_pkt(op_data, kind_psum, 0, 15, 32'hffff_ff00));
        wait_results("reconfig", num_col - 1, errs);
        send(make_pkt(op_data, kind_psum, 0, 13, 32'd42));
        wait_results("reconfig", num_col, errs);
        check_results("reconfig", 1'b0, errs);
        report("reconfig", errs);

        // random traffic, psum packets spaced for the collector
        errs = 0;
        for (int i = 0; i < 300; i++) begin
            bus_pkt_t p;
            p = random_pkt();
            send(p);
            if (p.op == op_data && p.kind == kind_psum) begin
                idle(num_col + 3);
            end
        end
        wait_results("random", exp_q.size(), errs);
        check_results("random", 1'b0, errs);
        report("random", errs);

        $display("tests run %0d, passed %0d, failed %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== hw/pe_row.sv ====
`timescale 1ns/1ps

module pe_row import pe_row_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      bus_stb,
    input  bus_pkt_t  pkt,
    output logic      out_stb,
    output result_t   out
);

    // multicaster to columns
    logic [num_col-1:0]              ifmap_hit;
    logic [data_w-1:0]               ifmap;
    logic [num_col-1:0]              fltr_hit;
    logic [data_w-1:0]               fltr;
    logic [num_col-1:0]              psum_hit;
    logic [psum_w-1:0]               psum;

    // columns to collector
    logic [num_col-1:0]              res_stb;
    logic [num_col-1:0][psum_w-1:0]  res;

    multi_caster u_multi_caster (
        .clk       (clk),
        .reset     (reset),
        .bus_stb   (bus_stb),
        .pkt       (pkt),
        .ifmap_hit (ifmap_hit),
        .ifmap     (ifmap),
        .fltr_hit  (fltr_hit),
        .fltr      (fltr),
        .psum_hit  (psum_hit),
        .psum      (psum)
    );

    // one PE per column, each picks its own hit bits
    for (genvar c = 0; c < num_col; c++) begin : g_col
        mac_pe u_pe (
            .clk       (clk),
            .reset     (reset),
            .ifmap_stb (ifmap_hit[c]),
            .ifmap     (ifmap),
            .fltr_stb  (fltr_hit[c]),
            .fltr      (fltr),
            .psum_stb  (psum_hit[c]),
            .psum      (psum),
            .res_stb   (res_stb[c]),
            .res       (res[c])
        );
    end

    result_collector u_collector (
        .clk     (clk),
        .reset   (reset),
        .res_stb (res_stb),
        .res     (res),
        .out_stb (out_stb),
        .out     (out)
    );

endmodule

// ==== hw/result_collector.sv ====
`timescale 1ns/1ps

module result_collector import pe_row_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [num_col-1:0]               res_stb,
    input  logic [num_col-1:0][psum_w-1:0]   res,
    output logic                             out_stb,
    output result_t                          out
);

    // one-deep slot per column
    logic [num_col-1:0]  pending_q;
    logic [psum_w-1:0]   val_q [num_col];

    // lowest pending column this cycle
    logic [num_col-1:0]  grant;
    logic [col_w-1:0]    sel;

    always_comb begin
        grant = '0;
        sel   = '0;
        // walk downwards so the lowest set column wins
        for (int c = num_col - 1; c >= 0; c--) begin
            if (pending_q[c]) begin
                grant    = '0;
                grant[c] = 1'b1;
                sel      = col_w'(c);
            end
        end
    end

    // emit straight from the slots, no extra stage
    assign out_stb   = |pending_q;
    assign out.col   = sel;
    assign out.value = val_q[sel];

    // drain the granted slot, fill newly arrived ones
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~grant) | res_stb;
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        for (int c = 0; c < num_col; c++) begin
            if (res_stb[c]) begin
                val_q[c] <= res[c];
            end
        end
    end

    // no back-pressure, psum spacing upstream must leave the slot empty
    a_no_overrun: assert property (
        @(posedge clk) disable iff (reset)
        (res_stb & pending_q) == '0
    );

endmodule

// ==== hw/mac_pe.sv ====
`timescale 1ns/1ps

module mac_pe import pe_row_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               ifmap_stb,
    input  logic [data_w-1:0]  ifmap,
    input  logic               fltr_stb,
    input  logic [data_w-1:0]  fltr,
    input  logic               psum_stb,
    input  logic [psum_w-1:0]  psum,
    output logic               res_stb,
    output logic [psum_w-1:0]  res
);

    // latest operands delivered to this column
    logic [data_w-1:0]         ifmap_q;
    logic [data_w-1:0]         fltr_q;

    // signed product sign extended to the psum width
    logic signed [psum_w-1:0]  product;

    // both operands signed so the multiply is a signed 16x16
    assign product = $signed(ifmap_q) * $signed(fltr_q);

    // operand registers cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            ifmap_q <= '0;
            fltr_q  <= '0;
        end else begin
            if (ifmap_stb) begin
                ifmap_q <= ifmap;
            end
            if (fltr_stb) begin
                fltr_q <= fltr;
            end
        end
    end

    // result strobe follows psum by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            res_stb <= 1'b0;
        end else begin
            res_stb <= psum_stb;
        end
    end

    // accumulate with wrap modulo 2^psum_w
    always_ff @(posedge clk) begin
        if (psum_stb) begin
            res <= psum + product;
        end
    end

    // one bus packet per cycle keeps operand updates
    // apart from the accumulate
    a_no_overlap: assert property (
        @(posedge clk) disable iff (reset)
        psum_stb |-> !(ifmap_stb || fltr_stb)
    );

endmodule

// ==== hw/multi_caster.sv ====
`timescale 1ns/1ps

module multi_caster import pe_row_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                bus_stb,
    input  bus_pkt_t            pkt,
    output logic [num_col-1:0]  ifmap_hit,
    output logic [data_w-1:0]   ifmap,
    output logic [num_col-1:0]  fltr_hit,
    output logic [data_w-1:0]   fltr,
    output logic [num_col-1:0]  psum_hit,
    output logic [psum_w-1:0]   psum
);

    // which caster owns this cycle's packet
    logic ifmap_sel;
    logic fltr_sel;
    logic psum_sel;

    // cfg versus data, shared by all three
    logic is_cfg;

    always_comb begin
        ifmap_sel = 1'b0;
        fltr_sel  = 1'b0;
        psum_sel  = 1'b0;
        if (bus_stb) begin
            case (pkt.kind)
                kind_ifmap: ifmap_sel = 1'b1;
                kind_fltr:  fltr_sel  = 1'b1;
                kind_psum:  psum_sel  = 1'b1;
                // unused kind code, dropped
                default:    ;
            endcase
        end
    end

    assign is_cfg = (pkt.op == op_cfg);

    // ifmap path, low half of the payload
    caster #(.width(data_w)) ifmap_caster (
        .clk      (clk),
        .reset    (reset),
        .cfg_stb  (ifmap_sel && is_cfg),
        .data_stb (ifmap_sel && !is_cfg),
        .col      (pkt.col),
        .id       (pkt.id),
        .data_in  (pkt.data[data_w-1:0]),
        .hit      (ifmap_hit),
        .data_out (ifmap)
    );

    // filter weight path
    caster #(.width(data_w)) fltr_caster (
        .clk      (clk),
        .reset    (reset),
        .cfg_stb  (fltr_sel && is_cfg),
        .data_stb (fltr_sel && !is_cfg),
        .col      (pkt.col),
        .id       (pkt.id),
        .data_in  (pkt.data[data_w-1:0]),
        .hit      (fltr_hit),
        .data_out (fltr)
    );

    // psum path, full width
    caster #(.width(psum_w)) psum_caster (
        .clk      (clk),
        .reset    (reset),
        .cfg_stb  (psum_sel && is_cfg),
        .data_stb (psum_sel && !is_cfg),
        .col      (pkt.col),
        .id       (pkt.id),
        .data_in  (pkt.data),
        .hit      (psum_hit),
        .data_out (psum)
    );

endmodule

// ==== hw/caster.sv ====
`timescale 1ns/1ps

module caster import pe_row_pkg::*; #(
    parameter int width = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                cfg_stb,
    input  logic                data_stb,
    input  logic [col_w-1:0]    col,
    input  logic [id_w-1:0]     id,
    input  logic [width-1:0]    data_in,
    output logic [num_col-1:0]  hit,
    output logic [width-1:0]    data_out
);

    // per-column tag table
    logic [num_col-1:0]  valid_q;
    logic [id_w-1:0]     tag_q [num_col];

    // columns whose stored tag equals the incoming id
    logic [num_col-1:0]  match;

    always_comb begin
        for (int c = 0; c < num_col; c++) begin
            // unconfigured columns never match
            match[c] = valid_q[c] && (tag_q[c] == id);
        end
    end

    // control state, valid bits and the hit pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            hit     <= '0;
        end else begin
            if (cfg_stb) begin
                valid_q[col] <= 1'b1;
            end
            // hit is a one-cycle pulse per data packet
            if (data_stb) begin
                hit <= match;
            end else begin
                hit <= '0;
            end
        end
    end

    // tag entries and the word handed to the columns
    always_ff @(posedge clk) begin
        if (cfg_stb) begin
            // new tag is seen by the very next packet
            tag_q[col] <= id;
        end
        if (data_stb) begin
            // one word shared by every hit column
            data_out <= data_in;
        end
    end

    // multi_caster routes one packet per cycle so a caster
    // is configured or fed data in a given cycle but not both
    a_one_op: assert property (
        @(posedge clk) disable iff (reset)
        !(cfg_stb && data_stb)
    );

endmodule

// ==== hw/pe_row_pkg.sv ====
package pe_row_pkg;

    // ifmap and filter word width
    localparam int data_w = 16;

    // partial sum width, wide enough for a full 16x16 product
    localparam int psum_w = 32;

    // PE columns in one row
    localparam int num_col = 4;

    // multicast tag width
    localparam int id_w = 4;

    // column index width, log2 of num_col
    localparam int col_w = 2;

    // what a bus packet does
    // cfg rewrites one column's tag, data is matched against all tags
    typedef enum logic {
        op_cfg,
        op_data
    } bus_op_e;

    // which multicaster the packet is meant for
    typedef enum logic [1:0] {
        kind_ifmap,
        kind_fltr,
        kind_psum
    } data_kind_e;

    // one packet on the shared bus
    typedef struct packed {
        // cfg or data
        bus_op_e             op;
        // target multicaster
        data_kind_e          kind;
        // column to configure, ignored on data
        logic [col_w-1:0]    col;
        // new tag on cfg, match tag on data
        logic [id_w-1:0]     id;
        // payload, ifmap and filter use the low data_w bits
        logic [psum_w-1:0]   data;
    } bus_pkt_t;

    // one finished psum leaving the row
    typedef struct packed {
        // column that produced it
        logic [col_w-1:0]    col;
        // accumulated value
        logic [psum_w-1:0]   value;
    } result_t;

endpackage
